/* hdl/avmm_translator_defines.svh */
// Avalon-MM master translator widths
// Word side, byte side and the fixed word-to-symbol ratio
`ifndef AVMM_TRANSLATOR_DEFINES_SVH
`define AVMM_TRANSLATOR_DEFINES_SVH

// ----------------------------------------------------------------------
// Word-addressed master side
// ----------------------------------------------------------------------
`define AVMM_AV_ADDR_W        16
`define AVMM_AV_BURST_W       4

// ----------------------------------------------------------------------
// Byte-addressed universal side
// ----------------------------------------------------------------------
`define AVMM_UAV_ADDR_W       18
`define AVMM_UAV_BURST_W      6

// Shared data path
`define AVMM_DATA_W           32
`define AVMM_BYTEEN_W         4

// Four byte symbols per word, so addresses and counts shift by two
`define AVMM_SYMBOLS_PER_WORD 4
`define AVMM_WORD_SHIFT       2

`endif

/* hdl/avmm_translator_pkg.sv */
// Avalon-MM master translator types
// Vectors for addresses, data, byte enables and burst counts
`default_nettype none

`include "avmm_translator_defines.svh"

package avmm_translator_pkg;

   // Word-addressed master side
   typedef logic [`AVMM_AV_ADDR_W-1:0]   av_addr_t;
   typedef logic [`AVMM_AV_BURST_W-1:0]  av_burst_t;

   // Byte-addressed universal side
   typedef logic [`AVMM_UAV_ADDR_W-1:0]  uav_addr_t;
   typedef logic [`AVMM_UAV_BURST_W-1:0] uav_burst_t;

   // Payload, identical on both sides
   typedef logic [`AVMM_DATA_W-1:0]      data_t;
   typedef logic [`AVMM_BYTEEN_W-1:0]    byteen_t;

endpackage

`default_nettype wire

/* hdl/avmm_beat_if.sv */
// Beat control between the transfer controller and the burst tracker
// Carries the burst start, beat events and the last-beat flag
`timescale 1ns/1ps
`default_nettype none

interface avmm_beat_if;

   // Begin-burst strobe, selects the converted input in the tracker
   logic burst_start;
   // First beat offered or still stalled
   logic load_first;
   // Later beat offered or still stalled
   logic step_beat;
   // Command accepted this cycle
   logic beat_done;
   // Remaining count equals one word
   logic last_beat;

   modport controller (
      output burst_start,
      output load_first,
      output step_beat,
      output beat_done,
      input  last_beat
   );

   modport tracker (
      input  burst_start,
      input  load_first,
      input  step_beat,
      input  beat_done,
      output last_beat
   );

endinterface

`default_nettype wire

/* hdl/transfer_control.sv */
// Transfer controller for the Avalon-MM master translator
// Generates begin strobes, tracks burst stalls and signals beat events
`timescale 1ns/1ps
`default_nettype none

module transfer_control (
   input  logic            clk,
   input  logic            reset,
   input  logic            write,
   input  logic            read,
   input  logic            uav_waitrequest,
   output logic            begin_transfer,
   output logic            begin_burst_transfer,
   avmm_beat_if.controller beat
);

   logic command;
   logic accepted;
   logic load_first;
   logic step_beat;
   logic end_begintransfer;
   logic end_beginbursttransfer;
   logic first_burst_stalled;
   logic burst_stalled;

   assign command  = write | read;
   assign accepted = command & ~uav_waitrequest;

   // ----------------------------------------------------------------------
   // Begin strobes
   // ----------------------------------------------------------------------
   // Begintransfer only in the first offered cycle of each command
   assign begin_transfer = command & ~end_begintransfer;

   // Every read is its own burst, writes only on beat zero
   assign begin_burst_transfer = read ? begin_transfer
                                      : begin_transfer & ~end_beginbursttransfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begintransfer <= 1'b0;
      end else if (!uav_waitrequest) begin
         end_begintransfer <= 1'b0;
      end else if (begin_transfer) begin
         end_begintransfer <= 1'b1;
      end
   end

   // Set inside a write burst, cleared once its last beat is taken
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_beginbursttransfer <= 1'b0;
      end else if (read || (write && accepted && beat.last_beat)) begin
         end_beginbursttransfer <= 1'b0;
      end else if (write && accepted) begin
         end_beginbursttransfer <= 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Stall tracking
   // ----------------------------------------------------------------------
   assign load_first = begin_burst_transfer | first_burst_stalled;
   assign step_beat  = begin_transfer | burst_stalled;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         first_burst_stalled <= 1'b0;
         burst_stalled       <= 1'b0;
      end else if (load_first) begin
         first_burst_stalled <= uav_waitrequest;
      end else if (step_beat) begin
         burst_stalled <= uav_waitrequest;
      end
   end

   // Beat events for the tracker
   assign beat.burst_start = begin_burst_transfer;
   assign beat.load_first  = load_first;
   assign beat.step_beat   = step_beat;
   assign beat.beat_done   = accepted;

   // Burst strobe only where a transfer truly starts, never after a stalled cycle
   a_burst_needs_transfer : assert property (
      @(posedge clk) disable iff (reset)
      begin_burst_transfer |-> !$past(command && uav_waitrequest)
   ) else $error("begin_burst_transfer in a stalled cycle of a command");

endmodule

`default_nettype wire

/* hdl/burst_address_tracker.sv */
// Burst address tracker for the Avalon-MM master translator
// Converts word units to bytes and symbols, steps address and count per beat
`timescale 1ns/1ps
`default_nettype none

`include "avmm_translator_defines.svh"

module burst_address_tracker (
   input  logic                           clk,
   input  logic                           reset,
   input  avmm_translator_pkg::av_addr_t   av_address,
   input  avmm_translator_pkg::av_burst_t  av_burstcount,
   input  logic                           write,
   input  logic                           uav_waitrequest,
   output avmm_translator_pkg::uav_addr_t  uav_address,
   output avmm_translator_pkg::uav_burst_t uav_burstcount,
   avmm_beat_if.tracker                   beat
);

   import avmm_translator_pkg::*;

   // One word expressed in bytes and in symbols
   localparam uav_addr_t  WORD_BYTES   = uav_addr_t'(`AVMM_SYMBOLS_PER_WORD);
   localparam uav_burst_t WORD_SYMBOLS = uav_burst_t'(`AVMM_SYMBOLS_PER_WORD);

   uav_addr_t  addr_pre;
   uav_burst_t count_pre;
   uav_addr_t  addr_reg;
   uav_burst_t count_reg;
   uav_addr_t  next_base;
   logic       last_pre;
   logic       last_reg;

   // ----------------------------------------------------------------------
   // Unit conversion
   // ----------------------------------------------------------------------
   assign addr_pre  = {av_address, {`AVMM_WORD_SHIFT{1'b0}}};
   assign count_pre = {av_burstcount, {`AVMM_WORD_SHIFT{1'b0}}};

   // Base for the next beat, fresh input at burst start
   assign next_base = beat.burst_start ? addr_pre : addr_reg;

   // ----------------------------------------------------------------------
   // Per-beat registers
   // ----------------------------------------------------------------------
   // Holds under back-pressure, one word further after an accepted write
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_reg <= '0;
      end else if (uav_waitrequest) begin
         addr_reg <= next_base;
      end else if (write) begin
         addr_reg <= next_base + WORD_BYTES;
      end
   end

   // Loaded from the converted count on the first beat
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         count_reg <= '0;
      end else if (beat.load_first) begin
         if (beat.beat_done) begin
            count_reg <= count_pre - WORD_SYMBOLS;
         end else begin
            count_reg <= count_pre;
         end
      end else if (beat.step_beat && beat.beat_done) begin
         count_reg <= count_reg - WORD_SYMBOLS;
      end
   end

   // ----------------------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------------------
   always_comb begin
      if (beat.burst_start) begin
         uav_address    = addr_pre;
         uav_burstcount = count_pre;
      end else begin
         uav_address    = addr_reg;
         uav_burstcount = count_reg;
      end
   end

   // Compare both sources ahead of the mux
   assign last_pre       = (count_pre == WORD_SYMBOLS);
   assign last_reg       = (count_reg == WORD_SYMBOLS);
   assign beat.last_beat = beat.burst_start ? last_pre : last_reg;

   // A later beat always has at least one word left to send
   a_count_not_empty : assert property (
      @(posedge clk) disable iff (reset)
      (beat.step_beat && !beat.load_first) |-> (count_reg >= WORD_SYMBOLS)
   ) else $error("burst count register below one word on an offered beat");

endmodule

`default_nettype wire

/* hdl/avmm_master_translator.sv */
// Avalon-MM master translator top level
// Word-addressed master port in, byte-addressed universal master port out
`timescale 1ns/1ps
`default_nettype none

module avmm_master_translator (
   input  logic                            clk,
   input  logic                            reset,

   // Avalon-MM slave side, driven by the master
   input  logic                            av_write,
   input  logic                            av_read,
   input  avmm_translator_pkg::av_addr_t    av_address,
   input  avmm_translator_pkg::byteen_t     av_byteenable,
   input  avmm_translator_pkg::av_burst_t   av_burstcount,
   input  avmm_translator_pkg::data_t       av_writedata,
   output avmm_translator_pkg::data_t       av_readdata,
   output logic                            av_readdatavalid,
   output logic                            av_waitrequest,

   // Universal Avalon master side
   output logic                            uav_write,
   output logic                            uav_read,
   output avmm_translator_pkg::uav_addr_t   uav_address,
   output avmm_translator_pkg::uav_burst_t  uav_burstcount,
   output avmm_translator_pkg::byteen_t     uav_byteenable,
   output avmm_translator_pkg::data_t       uav_writedata,
   output logic                            uav_begintransfer,
   output logic                            uav_beginbursttransfer,
   input  avmm_translator_pkg::data_t       uav_readdata,
   input  logic                            uav_readdatavalid,
   input  logic                            uav_waitrequest
);

   avmm_beat_if beat0 ();

   // ----------------------------------------------------------------------
   // Pass-through paths
   // ----------------------------------------------------------------------
   assign uav_write        = av_write;
   assign uav_read         = av_read;
   assign uav_writedata    = av_writedata;
   assign uav_byteenable   = av_byteenable;

   assign av_readdata      = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;
   assign av_waitrequest   = uav_waitrequest;

   // ----------------------------------------------------------------------
   // Strobes and beat events
   // ----------------------------------------------------------------------
   transfer_control u_ctrl (
      .clk                  (clk),
      .reset                (reset),
      .write                (av_write),
      .read                 (av_read),
      .uav_waitrequest      (uav_waitrequest),
      .begin_transfer       (uav_begintransfer),
      .begin_burst_transfer (uav_beginbursttransfer),
      .beat                 (beat0.controller)
   );

   // Address and burst count per beat
   burst_address_tracker u_tracker (
      .clk             (clk),
      .reset           (reset),
      .av_address      (av_address),
      .av_burstcount   (av_burstcount),
      .write           (av_write),
      .uav_waitrequest (uav_waitrequest),
      .uav_address     (uav_address),
      .uav_burstcount  (uav_burstcount),
      .beat            (beat0.tracker)
   );

   // ----------------------------------------------------------------------
   // Master must hold its command while stalled
   // ----------------------------------------------------------------------
   a_input_stable : assert property (
      @(posedge clk) disable iff (reset)
      (av_waitrequest && (av_write || av_read)) |=>
         ($stable(av_write) && $stable(av_read) && $stable(av_address) &&
          $stable(av_byteenable) && $stable(av_burstcount) && $stable(av_writedata))
   ) else $error("command inputs changed while av_waitrequest was high");

endmodule

`default_nettype wire

/* verification/tb_avmm_translator.sv */
// Testbench for the Avalon-MM master translator
// Directed tests with a slave model that picks waitrequest and returns read data
`timescale 1ns/1ps
`default_nettype none

module tb_avmm_translator;

   import avmm_translator_pkg::*;

   localparam int CLK_HALF   = 20;
   localparam int DRIVE_DLY  = 2;
   localparam int CHECK_DLY  = 10;
   // All tests together stay well below a few hundred cycles, stalls included
   localparam int MAX_CYCLES = 2000;

   logic       clk;
   logic       reset;
   logic       av_write;
   logic       av_read;
   av_addr_t   av_address;
   byteen_t    av_byteenable;
   av_burst_t  av_burstcount;
   data_t      av_writedata;
   data_t      av_readdata;
   logic       av_readdatavalid;
   logic       av_waitrequest;
   logic       uav_write;
   logic       uav_read;
   uav_addr_t  uav_address;
   uav_burst_t uav_burstcount;
   byteen_t    uav_byteenable;
   data_t      uav_writedata;
   logic       uav_begintransfer;
   logic       uav_beginbursttransfer;
   data_t      uav_readdata;
   logic       uav_readdatavalid;
   logic       uav_waitrequest;

   int          errors;
   int          tests_run;
   int          cycles;

   avmm_master_translator dut0 (
      .clk                    (clk),
      .reset                  (reset),
      .av_write               (av_write),
      .av_read                (av_read),
      .av_address             (av_address),
      .av_byteenable          (av_byteenable),
      .av_burstcount          (av_burstcount),
      .av_writedata           (av_writedata),
      .av_readdata            (av_readdata),
      .av_readdatavalid       (av_readdatavalid),
      .av_waitrequest         (av_waitrequest),
      .uav_write              (uav_write),
      .uav_read               (uav_read),
      .uav_address            (uav_address),
      .uav_burstcount         (uav_burstcount),
      .uav_byteenable         (uav_byteenable),
      .uav_writedata          (uav_writedata),
      .uav_begintransfer      (uav_begintransfer),
      .uav_beginbursttransfer (uav_beginbursttransfer),
      .uav_readdata           (uav_readdata),
      .uav_readdatavalid      (uav_readdatavalid),
      .uav_waitrequest        (uav_waitrequest)
   );

   always #CLK_HALF clk = ~clk;

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   task automatic report_mismatch(input string msg);
      errors++;
      $display("mismatch at %0t ns: %s", $time, msg);
   endtask

   task automatic next_drive_slot();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   // Data patterns depend on the full word address and the beat
   function automatic data_t write_word(input av_addr_t addr, input int k);
      return data_t'((int'(addr) << 16) ^ (k * 32'h0101_0101) ^ 32'h5A5A_0000);
   endfunction

   function automatic data_t read_word(input av_addr_t addr, input int i);
      return data_t'(32'hC0DE_0000 ^ (int'(addr) << 4) ^ i);
   endfunction

   // One write burst of n beats, the slave stalls at random when asked to
   task automatic drive_write_burst(input av_addr_t addr, input int n, input bit random_stalls);
      int         k;
      bit         stall;
      bit         new_beat;
      uav_addr_t  exp_addr;
      uav_burst_t exp_count;
      k        = 0;
      new_beat = 1'b1;
      while (k < n) begin
         next_drive_slot();
         stall           = random_stalls && (($urandom % 3) == 0);
         av_write        = 1'b1;
         av_address      = addr;
         av_burstcount   = av_burst_t'(n);
         av_writedata    = write_word(addr, k);
         av_byteenable   = byteen_t'(15 - (k % 4));
         uav_waitrequest = stall;
         exp_addr        = uav_addr_t'(4 * (int'(addr) + k));
         exp_count       = uav_burst_t'(4 * (n - k));
         #CHECK_DLY;
         if ({uav_write, uav_read} !== 2'b10) begin
            report_mismatch($sformatf("beat %0d write/read %b, expected 10", k,
                                      {uav_write, uav_read}));
         end
         if ({uav_begintransfer, uav_beginbursttransfer} !== {new_beat, new_beat && (k == 0)}) begin
            report_mismatch($sformatf("beat %0d begin strobes %b, expected %b", k,
                                      {uav_begintransfer, uav_beginbursttransfer},
                                      {new_beat, new_beat && (k == 0)}));
         end
         if (uav_address !== exp_addr) begin
            report_mismatch($sformatf("beat %0d uav_address %0h, expected %0h", k,
                                      uav_address, exp_addr));
         end
         if (uav_burstcount !== exp_count) begin
            report_mismatch($sformatf("beat %0d uav_burstcount %0d, expected %0d", k,
                                      uav_burstcount, exp_count));
         end
         if ({uav_writedata, uav_byteenable} !== {av_writedata, av_byteenable}) begin
            report_mismatch($sformatf("beat %0d payload %h/%h, expected %h/%h", k,
                                      uav_writedata, uav_byteenable, av_writedata, av_byteenable));
         end
         if (av_waitrequest !== uav_waitrequest) begin
            report_mismatch($sformatf("av_waitrequest %b, expected %b", av_waitrequest,
                                      uav_waitrequest));
         end
         // Accepted on the coming edge when not stalled
         new_beat = !stall;
         if (!stall) begin
            k++;
         end
      end
      next_drive_slot();
      av_write        = 1'b0;
      uav_waitrequest = 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------
   task automatic check_reset_state();
      tests_run++;
      next_drive_slot();
      #CHECK_DLY;
      if ({uav_write, uav_read, uav_begintransfer, uav_beginbursttransfer} !== 4'b0000) begin
         report_mismatch($sformatf("idle outputs %b after reset, expected 0000",
                                   {uav_write, uav_read, uav_begintransfer,
                                    uav_beginbursttransfer}));
      end
   endtask

   task automatic single_write(input av_addr_t addr);
      tests_run++;
      drive_write_burst(addr, 1, 1'b0);
   endtask

   task automatic read_burst_with_data(input av_addr_t addr, input int n, input int latency);
      int         i;
      uav_addr_t  exp_addr;
      uav_burst_t exp_count;
      tests_run++;
      exp_addr  = uav_addr_t'(4 * int'(addr));
      exp_count = uav_burst_t'(4 * n);
      next_drive_slot();
      av_read         = 1'b1;
      av_address      = addr;
      av_burstcount   = av_burst_t'(n);
      uav_waitrequest = 1'b0;
      #CHECK_DLY;
      if ({uav_write, uav_read, uav_begintransfer, uav_beginbursttransfer} !== 4'b0111) begin
         report_mismatch($sformatf("read strobes %b, expected 0111",
                                   {uav_write, uav_read, uav_begintransfer,
                                    uav_beginbursttransfer}));
      end
      if ({uav_address, uav_burstcount} !== {exp_addr, exp_count}) begin
         report_mismatch($sformatf("read address %0h count %0d, expected %0h count %0d",
                                   uav_address, uav_burstcount, exp_addr, exp_count));
      end
      next_drive_slot();
      av_read = 1'b0;
      // Slave latency before the first word comes back
      repeat (latency) begin
         #CHECK_DLY;
         if (av_readdatavalid !== 1'b0) begin
            report_mismatch("av_readdatavalid high before the slave returned data");
         end
         next_drive_slot();
      end
      for (i = 0; i < n; i++) begin
         uav_readdatavalid = 1'b1;
         uav_readdata      = read_word(addr, i);
         #CHECK_DLY;
         if ({av_readdatavalid, av_readdata} !== {1'b1, read_word(addr, i)}) begin
            report_mismatch($sformatf("read word %0d valid %b data %h, expected 1 %h", i,
                                      av_readdatavalid, av_readdata, read_word(addr, i)));
         end
         next_drive_slot();
      end
      uav_readdatavalid = 1'b0;
   endtask

   task automatic plain_write_burst(input av_addr_t addr, input int n);
      tests_run++;
      drive_write_burst(addr, n, 1'b0);
   endtask

   task automatic stalled_write_bursts(input int bursts);
      av_addr_t addr;
      int       n;
      tests_run++;
      repeat (bursts) begin
         addr = av_addr_t'($urandom);
         n    = 1 + int'($urandom % 15);
         drive_write_burst(addr, n, 1'b1);
      end
   endtask

   initial begin
      void'($urandom(58086));
      errors            = 0;
      tests_run         = 0;
      cycles            = 0;
      clk               = 1'b0;
      reset             = 1'b1;
      av_write          = 1'b0;
      av_read           = 1'b0;
      av_address        = '0;
      av_byteenable     = '0;
      av_burstcount     = '0;
      av_writedata      = '0;
      uav_readdata      = '0;
      uav_readdatavalid = 1'b0;
      uav_waitrequest   = 1'b0;
      repeat (4) @(posedge clk);
      #DRIVE_DLY;
      reset = 1'b0;

      check_reset_state();
      single_write(16'h0123);
      single_write(16'hBEEF);
      read_burst_with_data(16'h0200, 4, 2);
      read_burst_with_data(16'h0404, 1, 0);
      plain_write_burst(16'h1000, 8);
      plain_write_burst(16'hFFF0, 15);
      stalled_write_bursts(6);
      repeat (2) next_drive_slot();

      $display("tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/avmm_translator_pkg.sv
hdl/avmm_beat_if.sv
hdl/transfer_control.sv
hdl/burst_address_tracker.sv
hdl/avmm_master_translator.sv
verification/tb_avmm_translator.sv

/* Makefile */
# Verilator simulation of the Avalon-MM master translator

TOP     := tb_avmm_translator
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log search decides the result, not the simulator's exit code
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || \
	   (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall +incdir+hdl --top-module avmm_master_translator \
	   hdl/avmm_translator_pkg.sv \
	   hdl/avmm_beat_if.sv \
	   hdl/transfer_control.sv \
	   hdl/burst_address_tracker.sv \
	   hdl/avmm_master_translator.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
